//--- rtl/CtrlPkg.sv
`default_nettype none

package CtrlPkg;

    // Lane counts of the core
    localparam int UopLanes = 2;
    localparam int WbLanes = 3;

    // One register access from the bus
    typedef struct packed {
        logic        en;
        logic        we;
        logic [3:0]  wmask;
        // Bit 4 picks the perf bank
        logic [5:0]  addr;
        logic [31:0] wdata;
    } BusReq;

    // Per-cycle events from the pipeline
    typedef struct packed {
        logic [UopLanes-1:0] fetchValid;
        logic [WbLanes-1:0]  execValid;
        logic [UopLanes-1:0] commitValid;
        logic                branchTaken;
        logic                commitBranch;
    } CoreEvents;

    // Interrupt source and flags
    typedef struct packed {
        logic [31:0] src;
        logic [1:0]  flags;
    } IrqInfo;

    // GPIO timer config word, top byte unused
    typedef struct packed {
        logic [7:0] spare;
        logic [7:0] clearMask;
        logic [7:0] setMask;
        logic [7:0] period;
    } GpioCfg;

    // Control register indices
    localparam logic [2:0] RegIrqAddr  = 3'd0;
    localparam logic [2:0] RegIrqSrc   = 3'd1;
    localparam logic [2:0] RegIrqFlags = 3'd2;
    localparam logic [2:0] RegScratch0 = 3'd3;
    localparam logic [2:0] RegScratch1 = 3'd4;
    localparam logic [2:0] RegGpioOut  = 3'd5;
    localparam logic [2:0] RegGpioCfg  = 3'd6;
    localparam logic [2:0] RegGpioIn   = 3'd7;

    // Perf counter indices
    localparam logic [2:0] PerfCycles      = 3'd0;
    localparam logic [2:0] PerfFetched     = 3'd1;
    localparam logic [2:0] PerfExecuted    = 3'd2;
    localparam logic [2:0] PerfCommitted   = 3'd3;
    localparam logic [2:0] PerfBranches    = 3'd4;
    localparam logic [2:0] PerfComBranches = 3'd5;

    // Byte-enable merge of new data into an old word
    function automatic logic [31:0] mergeBytes(
        input logic [31:0] oldWord,
        input logic [31:0] newWord,
        input logic [3:0]  mask
    );
        logic [31:0] result;
        result = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                result[b*8 +: 8] = newWord[b*8 +: 8];
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- rtl/EventCounter.sv
`default_nettype none

module EventCounter #(
    parameter int Lanes = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [Lanes-1:0] hit,
    output logic [63:0]      count
);

    // Wide enough to hold Lanes itself
    localparam int SumW = $clog2(Lanes + 1);

    logic [SumW-1:0] hitSum;

    // Population count of the hit lanes
    always_comb begin
        hitSum = '0;
        for (int i = 0; i < Lanes; i++) begin
            hitSum = hitSum + SumW'(hit[i]);
        end
    end

    // 64-bit accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 64'd0;
        end else begin
            count <= count + 64'(hitSum);
        end
    end

endmodule

`default_nettype wire

//--- rtl/PerfBank.sv
`default_nettype none

module PerfBank #(
    parameter int UopLanes = CtrlPkg::UopLanes,
    parameter int WbLanes  = CtrlPkg::WbLanes
) (
    input  logic               clk,
    input  logic               rst,
    input  CtrlPkg::CoreEvents events,
    input  logic [2:0]         perfSel,
    input  logic               perfHigh,
    output logic [31:0]        perfData
);

    import CtrlPkg::*;

    logic [63:0] cycles;
    logic [63:0] fetched;
    logic [63:0] executed;
    logic [63:0] committed;
    logic [63:0] branches;
    logic [63:0] comBranches;
    logic [63:0] selCount;

    // Free-running cycle count
    EventCounter #(.Lanes(1)) cycleCnt (
        .clk   (clk),
        .rst   (rst),
        .hit   (1'b1),
        .count (cycles)
    );

    EventCounter #(.Lanes(UopLanes)) fetchCnt (
        .clk   (clk),
        .rst   (rst),
        .hit   (events.fetchValid),
        .count (fetched)
    );

    // One count per writeback lane
    EventCounter #(.Lanes(WbLanes)) execCnt (
        .clk   (clk),
        .rst   (rst),
        .hit   (events.execValid),
        .count (executed)
    );

    EventCounter #(.Lanes(UopLanes)) commitCnt (
        .clk   (clk),
        .rst   (rst),
        .hit   (events.commitValid),
        .count (committed)
    );

    EventCounter #(.Lanes(1)) branchCnt (
        .clk   (clk),
        .rst   (rst),
        .hit   (events.branchTaken),
        .count (branches)
    );

    EventCounter #(.Lanes(1)) comBranchCnt (
        .clk   (clk),
        .rst   (rst),
        .hit   (events.commitBranch),
        .count (comBranches)
    );

    // Counter select, zero for unused slots
    always_comb begin
        case (perfSel)
            PerfCycles:      selCount = cycles;
            PerfFetched:     selCount = fetched;
            PerfExecuted:    selCount = executed;
            PerfCommitted:   selCount = committed;
            PerfBranches:    selCount = branches;
            PerfComBranches: selCount = comBranches;
            default:         selCount = 64'd0;
        endcase
    end

    // Half select
    assign perfData = perfHigh ? selCount[63:32] : selCount[31:0];

endmodule

`default_nettype wire

//--- rtl/GpioPort.sv
`default_nettype none

module GpioPort (
    input  logic        clk,
    input  logic        rst,
    input  logic        gpioWrEn,
    input  logic        gpioCfgWrEn,
    input  logic [3:0]  wmask,
    input  logic [31:0] wdata,
    output logic [31:0] gpioWord,
    output logic [31:0] cfgWord,
    output logic [15:0] gpioOe,
    output logic [15:0] gpioOut
);

    import CtrlPkg::*;

    GpioCfg      cfg;
    logic [7:0]  countdown;
    logic [31:0] timedWord;

    // Auto set and clear on the upper output byte
    always_comb begin
        timedWord = gpioWord;
        if (countdown == 8'd0) begin
            timedWord[31:24] = (gpioWord[31:24] | cfg.setMask) & ~cfg.clearMask;
        end
    end

    // Output word and countdown
    always_ff @(posedge clk) begin
        if (rst) begin
            gpioWord  <= 32'd0;
            countdown <= 8'd0;
        end else begin
            // Wraps from 0 to 255
            countdown <= countdown - 8'd1;
            if (gpioWrEn) begin
                // Written bytes win over the timed update
                gpioWord  <= mergeBytes(timedWord, wdata, wmask);
                countdown <= cfg.period;
            end else begin
                gpioWord <= timedWord;
            end
        end
    end

    // Timer configuration
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (gpioCfgWrEn) begin
            cfg <= GpioCfg'(mergeBytes(cfg, wdata, wmask));
        end
    end

    assign cfgWord = cfg;

    // Low half enables, high half drives the pins
    assign gpioOe  = gpioWord[15:0];
    assign gpioOut = gpioWord[31:16];

endmodule

`default_nettype wire

//--- rtl/CtrlRegFile.sv
`default_nettype none

module CtrlRegFile (
    input  logic            clk,
    input  logic            rst,
    input  CtrlPkg::BusReq  req,
    input  logic            irqTaken,
    input  CtrlPkg::IrqInfo irq,
    input  logic [15:0]     gpioIn,
    input  logic [31:0]     perfData,
    input  logic [31:0]     gpioWord,
    input  logic [31:0]     cfgWord,
    output logic [2:0]      perfSel,
    output logic            perfHigh,
    output logic            gpioWrEn,
    output logic            gpioCfgWrEn,
    output logic [3:0]      wmask,
    output logic [31:0]     wdata,
    output logic [31:0]     rdata,
    output logic [31:0]     irqAddr
);

    import CtrlPkg::*;

    BusReq       reqQ;
    logic [2:0]  regSel;
    logic        isPerf;
    logic        ctrlWrite;
    logic        readExec;
    logic [31:0] readVal;

    // Handler, source, flags and scratch words
    logic [31:0] regs [0:4];

    // Request stage, executes one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            reqQ <= '0;
        end else begin
            reqQ <= req;
        end
    end

    // Decode of the registered request
    assign regSel    = reqQ.addr[2:0];
    assign isPerf    = reqQ.addr[4];
    assign ctrlWrite = reqQ.en & reqQ.we & ~isPerf;
    assign readExec  = reqQ.en & ~reqQ.we;

    // Counter and half for PerfBank
    assign perfSel  = reqQ.addr[3:1];
    assign perfHigh = reqQ.addr[0];

    // GPIO writes go to GpioPort
    assign gpioWrEn    = ctrlWrite && (regSel == RegGpioOut);
    assign gpioCfgWrEn = ctrlWrite && (regSel == RegGpioCfg);
    assign wmask       = reqQ.wmask;
    assign wdata       = reqQ.wdata;

    // Local registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 5; i++) begin
                regs[i] <= 32'd0;
            end
        end else begin
            // Byte-masked bus write
            if (ctrlWrite && regSel <= RegScratch1) begin
                regs[regSel] <= mergeBytes(regs[regSel], reqQ.wdata, reqQ.wmask);
            end
            // Capture overrides a write at the same edge
            if (irqTaken) begin
                regs[RegIrqSrc]   <= irq.src;
                regs[RegIrqFlags] <= {30'd0, irq.flags};
            end
        end
    end

    // Read source select
    always_comb begin
        if (isPerf) begin
            readVal = perfData;
        end else begin
            case (regSel)
                RegGpioOut: readVal = gpioWord;
                RegGpioCfg: readVal = cfgWord;
                // Pins only in the low half
                RegGpioIn:  readVal = {16'd0, gpioIn};
                default:    readVal = regs[regSel];
            endcase
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= 32'd0;
        end else if (readExec) begin
            rdata <= readVal;
        end
    end

    assign irqAddr = regs[RegIrqAddr];

endmodule

`default_nettype wire

//--- rtl/CtrlSubsystem.sv
`default_nettype none

module CtrlSubsystem #(
    parameter int UopLanes = CtrlPkg::UopLanes,
    parameter int WbLanes  = CtrlPkg::WbLanes
) (
    input  logic               clk,
    input  logic               rst,
    input  CtrlPkg::BusReq     req,
    input  CtrlPkg::CoreEvents events,
    input  logic               irqTaken,
    input  CtrlPkg::IrqInfo    irq,
    input  logic [15:0]        gpioIn,
    output logic [31:0]        rdata,
    output logic [31:0]        irqAddr,
    output logic [15:0]        gpioOe,
    output logic [15:0]        gpioOut
);

    // Register file to perf bank
    logic [2:0]  perfSel;
    logic        perfHigh;
    logic [31:0] perfData;

    // Register file to GPIO port
    logic        gpioWrEn;
    logic        gpioCfgWrEn;
    logic [3:0]  wmask;
    logic [31:0] wdata;
    logic [31:0] gpioWord;
    logic [31:0] cfgWord;

    CtrlRegFile regFile (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .irqTaken    (irqTaken),
        .irq         (irq),
        .gpioIn      (gpioIn),
        .perfData    (perfData),
        .gpioWord    (gpioWord),
        .cfgWord     (cfgWord),
        .perfSel     (perfSel),
        .perfHigh    (perfHigh),
        .gpioWrEn    (gpioWrEn),
        .gpioCfgWrEn (gpioCfgWrEn),
        .wmask       (wmask),
        .wdata       (wdata),
        .rdata       (rdata),
        .irqAddr     (irqAddr)
    );

    PerfBank #(
        .UopLanes (UopLanes),
        .WbLanes  (WbLanes)
    ) perfBank (
        .clk      (clk),
        .rst      (rst),
        .events   (events),
        .perfSel  (perfSel),
        .perfHigh (perfHigh),
        .perfData (perfData)
    );

    GpioPort gpioPort (
        .clk         (clk),
        .rst         (rst),
        .gpioWrEn    (gpioWrEn),
        .gpioCfgWrEn (gpioCfgWrEn),
        .wmask       (wmask),
        .wdata       (wdata),
        .gpioWord    (gpioWord),
        .cfgWord     (cfgWord),
        .gpioOe      (gpioOe),
        .gpioOut     (gpioOut)
    );

endmodule

`default_nettype wire

//--- verif/TbClock.sv
`default_nettype none

module TbClock (
    output logic clk
);

    // Period of 8, starts low
    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- verif/CtrlTb.sv
`default_nettype none

module CtrlTb;

    import CtrlPkg::*;

    logic        clk;
    logic        rst;
    BusReq       req;
    CoreEvents   events;
    logic        irqTaken;
    IrqInfo      irq;
    logic [15:0] gpioIn;
    logic [31:0] rdata;
    logic [31:0] irqAddr;
    logic [15:0] gpioOe;
    logic [15:0] gpioOut;

    // Reference model state
    logic [31:0] lcgState;
    logic [31:0] modelRegs [0:4];
    logic [63:0] modelCount [0:5];
    logic [63:0] perfSnap [0:5];
    int          checkCount;
    int          errorCount;

    TbClock clkGen (.clk(clk));

    CtrlSubsystem #(.UopLanes(UopLanes), .WbLanes(WbLanes)) dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .events   (events),
        .irqTaken (irqTaken),
        .irq      (irq),
        .gpioIn   (gpioIn),
        .rdata    (rdata),
        .irqAddr  (irqAddr),
        .gpioOe   (gpioOe),
        .gpioOut  (gpioOut)
    );

    // LCG, two steps per word, upper bits only
    function automatic logic [31:0] nextRand();
        logic [15:0] hi;
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        hi = lcgState[31:16];
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {hi, lcgState[31:16]};
    endfunction

    function automatic int countOnes(input logic [7:0] v);
        int n;
        n = 0;
        for (int b = 0; b < 8; b++) begin
            n = n + v[b];
        end
        return n;
    endfunction

    // Byte enables expanded to a bit mask
    function automatic logic [31:0] applyWrite(input logic [31:0] oldWord,
                                               input logic [31:0] newWord,
                                               input logic [3:0] mask);
        logic [31:0] bits;
        bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (oldWord & ~bits) | (newWord & bits);
    endfunction

    // Counter model, index 0 is the edge count since reset
    always @(posedge clk) begin
        if (rst) begin
            modelCount[0] <= 64'd0;
            modelCount[1] <= 64'd0;
            modelCount[2] <= 64'd0;
            modelCount[3] <= 64'd0;
            modelCount[4] <= 64'd0;
            modelCount[5] <= 64'd0;
        end else begin
            modelCount[0] <= modelCount[0] + 64'd1;
            modelCount[1] <= modelCount[1] + 64'(countOnes(8'(events.fetchValid)));
            modelCount[2] <= modelCount[2] + 64'(countOnes(8'(events.execValid)));
            modelCount[3] <= modelCount[3] + 64'(countOnes(8'(events.commitValid)));
            modelCount[4] <= modelCount[4] + 64'(events.branchTaken);
            modelCount[5] <= modelCount[5] + 64'(events.commitBranch);
        end
    end

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkPerf(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkGpio(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Bounded wait, returns on a falling edge
    task automatic waitEdges(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // Taken at the first edge, executes at the second
    task automatic busRead(input logic [5:0] addr, output logic [31:0] data);
        req.en    = 1'b1;
        req.we    = 1'b0;
        req.wmask = 4'h0;
        req.addr  = addr;
        req.wdata = 32'd0;
        @(posedge clk);
        @(negedge clk);
        req = '0;
        // Counts before the execute edge
        for (int i = 0; i < 6; i++) begin
            perfSnap[i] = modelCount[i];
        end
        @(posedge clk);
        @(negedge clk);
        data = rdata;
    endtask

    // Optional capture pulse lands on the execute edge
    task automatic busWrite(input logic [5:0] addr, input logic [3:0] mask,
                            input logic [31:0] data, input logic capture);
        req.en    = 1'b1;
        req.we    = 1'b1;
        req.wmask = mask;
        req.addr  = addr;
        req.wdata = data;
        @(posedge clk);
        @(negedge clk);
        req = '0;
        irqTaken = capture;
        @(posedge clk);
        @(negedge clk);
        irqTaken = 1'b0;
    endtask

    // High half first, each half against its own snapshot
    task automatic readPerf(input logic [2:0] idx, output logic [63:0] got,
                            output logic [63:0] exp);
        logic [31:0] hiWord;
        logic [31:0] loWord;
        logic [63:0] hiSnap;
        busRead({2'b01, idx, 1'b1}, hiWord);
        hiSnap = perfSnap[idx];
        busRead({2'b01, idx, 1'b0}, loWord);
        got = {hiWord, loWord};
        exp = {hiSnap[63:32], perfSnap[idx][31:0]};
    endtask

    task automatic reportTest(input int num, input string name, input int errsBefore);
        $display("Test %0d %s: %0d errors", num, name, errorCount - errsBefore);
    endtask

    initial begin : mainSeq
        int          startErr;
        logic [31:0] rnd;
        logic [31:0] data;
        logic [3:0]  mask;
        logic [2:0]  regIdx;
        logic [63:0] got;
        logic [63:0] exp;
        logic [7:0]  period;
        logic [7:0]  setM;
        logic [7:0]  clrM;
        logic [7:0]  expUpper;
        logic [31:0] cfgVal;
        logic [31:0] outWord;

        lcgState   = 32'd42545;
        checkCount = 0;
        errorCount = 0;
        rst        = 1'b1;
        req        = '0;
        events     = '0;
        irqTaken   = 1'b0;
        irq        = '0;
        gpioIn     = 16'd0;
        for (int i = 0; i < 5; i++) begin
            modelRegs[i] = 32'd0;
        end
        // Reset for 3 cycles
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;

        // Reset values
        startErr = errorCount;
        checkWord("rdata", rdata, 32'd0);
        checkWord("irqAddr", irqAddr, 32'd0);
        checkGpio("gpioOe", gpioOe, 16'd0);
        checkGpio("gpioOut", gpioOut, 16'd0);
        for (int r = 0; r < 8; r++) begin
            busRead(6'(r), data);
            checkWord($sformatf("reg %0d", r), data, 32'd0);
        end
        reportTest(1, "reset values", startErr);

        // Byte-masked writes to handler and scratch
        startErr = errorCount;
        for (int n = 0; n < 16; n++) begin
            rnd = nextRand();
            regIdx = (rnd[1:0] == 2'd0) ? RegIrqAddr : (rnd[0] ? RegScratch0 : RegScratch1);
            mask = rnd[7:4];
            data = nextRand();
            busWrite({3'b000, regIdx}, mask, data, 1'b0);
            modelRegs[regIdx] = applyWrite(modelRegs[regIdx], data, mask);
            checkWord("irqAddr", irqAddr, modelRegs[RegIrqAddr]);
            busRead({3'b000, regIdx}, data);
            checkWord($sformatf("reg %0d", regIdx), data, modelRegs[regIdx]);
        end
        reportTest(2, "masked writes", startErr);

        // Interrupt capture, odd rounds collide with a bus write
        startErr = errorCount;
        for (int n = 0; n < 8; n++) begin
            irq.src   = nextRand();
            rnd       = nextRand();
            irq.flags = rnd[1:0];
            if (n % 2 == 1) begin
                regIdx = rnd[2] ? RegIrqSrc : RegIrqFlags;
                mask   = rnd[7:4];
                data   = nextRand();
                busWrite({3'b000, regIdx}, mask, data, 1'b1);
                modelRegs[regIdx] = applyWrite(modelRegs[regIdx], data, mask);
            end else begin
                irqTaken = 1'b1;
                @(posedge clk);
                @(negedge clk);
                irqTaken = 1'b0;
            end
            // Capture wins
            modelRegs[RegIrqSrc]   = irq.src;
            modelRegs[RegIrqFlags] = {30'd0, irq.flags};
            busRead({3'b000, RegIrqSrc}, data);
            checkWord("irq src reg", data, modelRegs[RegIrqSrc]);
            busRead({3'b000, RegIrqFlags}, data);
            checkWord("irq flags reg", data, modelRegs[RegIrqFlags]);
        end
        for (int n = 0; n < 4; n++) begin
            rnd = nextRand();
            gpioIn = rnd[15:0];
            busRead({3'b000, RegGpioIn}, data);
            checkWord("gpio in reg", data, {16'd0, rnd[15:0]});
        end
        reportTest(3, "interrupt capture and pins", startErr);

        // Random events, then every counter
        startErr = errorCount;
        for (int n = 0; n < 200; n++) begin
            rnd = nextRand();
            events = CoreEvents'(rnd[8:0]);
            @(posedge clk);
            @(negedge clk);
        end
        events = '0;
        for (int c = 0; c < 6; c++) begin
            readPerf(3'(c), got, exp);
            checkPerf($sformatf("perf counter %0d", c), got, exp);
        end
        reportTest(4, "perf counters", startErr);

        // GPIO timer set and clear
        startErr = errorCount;
        for (int n = 0; n < 3; n++) begin
            rnd     = nextRand();
            period  = 8'd4 + 8'(rnd[3:0]);
            setM    = rnd[15:8];
            clrM    = rnd[23:16];
            cfgVal  = {8'd0, clrM, setM, period};
            outWord = nextRand();
            busWrite({3'b000, RegGpioCfg}, 4'hF, cfgVal, 1'b0);
            busWrite({3'b000, RegGpioOut}, 4'hF, outWord, 1'b0);
            expUpper = (outWord[31:24] | setM) & ~clrM;
            waitEdges(int'(period) + 4);
            checkGpio("gpioOut", gpioOut, {expUpper, outWord[23:16]});
            checkGpio("gpioOe", gpioOe, outWord[15:0]);
            // One more wrap of the countdown
            waitEdges(260);
            checkGpio("gpioOut", gpioOut, {expUpper, outWord[23:16]});
            busRead({3'b000, RegGpioOut}, data);
            checkWord("gpio word reg", data, {expUpper, outWord[23:0]});
            busRead({3'b000, RegGpioCfg}, data);
            checkWord("gpio cfg reg", data, cfgVal);
        end
        reportTest(5, "gpio timer", startErr);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/CtrlPkg.sv
rtl/EventCounter.sv
rtl/PerfBank.sv
rtl/GpioPort.sv
rtl/CtrlRegFile.sv
rtl/CtrlSubsystem.sv
verif/TbClock.sv
verif/CtrlTb.sv
